/* src/noc_pkg.sv */
`default_nettype none

package noc_pkg;

  // one packet always serializes to this many 32-bit beats
  localparam int BEATS_PER_PACKET = 8;

  typedef struct packed {
    logic [31:0] hw_addr;  // physical node id
    logic [15:0] sw_addr;  // software thread id
    logic [6:0]  port;
    logic        flag;
  } noc_addr_t;

  typedef struct packed {
    noc_addr_t   dest_addr;
    noc_addr_t   src_addr;
    logic [31:0] lamport;  // logical timestamp
    logic [95:0] data;     // three payload words
  } packet_t;

  typedef struct packed {
    logic [31:0] data;
    logic        startofpacket;
    logic        endofpacket;
  } stream_beat_t;

  // receiver states in beat order
  // beat 1 and 3 carry {sw_addr, port, flag} in bits 31:8, low byte zero
  typedef enum logic [$clog2(BEATS_PER_PACKET)-1:0] {
    dest_addr0,  // dest hw_addr
    dest_addr1,  // dest sw word
    src_addr0,   // src hw_addr
    src_addr1,   // src sw word
    lamport,
    data0,       // data[31:0]
    data1,       // data[63:32]
    data2        // data[95:64], carries endofpacket
  } rx_state_t;

endpackage : noc_pkg

`default_nettype wire

/* src/packet_sender.sv */
`timescale 1ns/100ps
`default_nettype none

module packet_sender (
  input  logic                  clk,
  input  logic                  reset_n,
  input  noc_pkg::packet_t      send_packet,
  input  logic                  send_valid,
  output logic                  send_ready,
  output noc_pkg::stream_beat_t tx_beat,
  output logic                  tx_valid,
  input  logic                  tx_ready
);

  localparam int IDX_W = $clog2(noc_pkg::BEATS_PER_PACKET);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(noc_pkg::BEATS_PER_PACKET - 1);

  typedef enum logic {
    tx_idle,
    tx_send
  } tx_state_t;

  tx_state_t        state;
  noc_pkg::packet_t pkt;         // latched on accept
  logic [IDX_W-1:0] beat_idx;
  logic             beat_taken;
  logic [31:0]      beat_word;

  assign send_ready = (state == tx_idle);
  assign tx_valid   = (state == tx_send);
  assign beat_taken = tx_valid && tx_ready;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state    <= tx_idle;
      beat_idx <= '0;
    end else begin
      case (state)
        tx_idle: begin
          if (send_valid) begin
            state    <= tx_send;
            beat_idx <= '0;
          end
        end
        tx_send: begin
          if (beat_taken) begin
            if (beat_idx == LAST_IDX) begin
              state <= tx_idle;  // ready again next cycle
            end
            beat_idx <= beat_idx + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (send_valid && send_ready) begin
      pkt <= send_packet;
    end
  end

  always_comb begin
    case (beat_idx)
      3'd0:    beat_word = pkt.dest_addr.hw_addr;
      3'd1:    beat_word = {pkt.dest_addr.sw_addr, pkt.dest_addr.port,
                            pkt.dest_addr.flag, 8'h00};
      3'd2:    beat_word = pkt.src_addr.hw_addr;
      3'd3:    beat_word = {pkt.src_addr.sw_addr, pkt.src_addr.port,
                            pkt.src_addr.flag, 8'h00};
      3'd4:    beat_word = pkt.lamport;
      3'd5:    beat_word = pkt.data[31:0];
      3'd6:    beat_word = pkt.data[63:32];
      default: beat_word = pkt.data[95:64];
    endcase
  end

  assign tx_beat = '{
    data:          beat_word,
    startofpacket: (beat_idx == '0),
    endofpacket:   (beat_idx == LAST_IDX)
  };

  // stalled beat must survive until the FIFO takes it
  a_hold_while_stalled: assert property (@(posedge clk) disable iff (!reset_n)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_beat))
    else $error("%0t:%m - tx_beat changed while stalled", $time);

endmodule : packet_sender

`default_nettype wire

/* src/stream_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module stream_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  noc_pkg::stream_beat_t in_beat,
  input  logic                  in_valid,
  output logic                  in_ready,
  output noc_pkg::stream_beat_t out_beat,
  output logic                  out_valid,
  input  logic                  out_ready
);

  localparam int ADDR_W = $clog2(FIFO_DEPTH);

  noc_pkg::stream_beat_t mem [FIFO_DEPTH];

  // extra msb tells a wrapped full from empty
  logic [ADDR_W:0] wr_ptr;
  logic [ADDR_W:0] rd_ptr;
  logic [ADDR_W:0] count;
  logic            full;
  logic            empty;
  logic            wr_en;
  logic            rd_en;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                 (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
  assign count = wr_ptr - rd_ptr;  // wraps with the pointers

  assign in_ready  = !full;
  assign out_valid = !empty;
  assign out_beat  = mem[rd_ptr[ADDR_W-1:0]];  // head slot, no output reg

  assign wr_en = in_valid && in_ready;
  assign rd_en = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[ADDR_W-1:0]] <= in_beat;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // a write at full or a read at empty pushes count out of range
  a_count_in_range: assert property (@(posedge clk) disable iff (!reset_n)
    count <= FIFO_DEPTH)
    else $error("%0t:%m - occupancy %0d beyond depth", $time, count);

endmodule : stream_fifo

`default_nettype wire

/* src/packet_receiver.sv */
`timescale 1ns/100ps
`default_nettype none

module packet_receiver (
  input  logic                  clk,
  input  logic                  reset_n,
  input  noc_pkg::stream_beat_t rx_beat,
  input  logic                  rx_valid,
  output logic                  rx_ready,
  input  logic                  booting,
  output logic                  packet_valid,
  output noc_pkg::packet_t      packet_data,
  output logic                  receive_done,
  output logic                  receive_nearly_done
);

  noc_pkg::rx_state_t state;
  noc_pkg::packet_t   temp_packet;  // fields collected so far
  noc_pkg::packet_t   assembled;
  logic               beat_taken;
  logic [31:0]        word;

  assign beat_taken = rx_valid && rx_ready;
  assign word       = rx_beat.data;

  // last word goes straight to the output
  always_comb begin
    assembled             = temp_packet;
    assembled.data[95:64] = word;
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state               <= noc_pkg::dest_addr0;
      rx_ready            <= 1'b0;
      packet_valid        <= 1'b0;
      packet_data         <= '0;
      receive_done        <= 1'b0;
      receive_nearly_done <= 1'b0;
    end else begin
      rx_ready            <= ~booting;  // intake closed during boot
      packet_valid        <= 1'b0;
      receive_done        <= 1'b0;
      receive_nearly_done <= 1'b0;
      if (beat_taken) begin
        case (state)
          noc_pkg::dest_addr0: state <= noc_pkg::dest_addr1;
          noc_pkg::dest_addr1: state <= noc_pkg::src_addr0;
          noc_pkg::src_addr0:  state <= noc_pkg::src_addr1;
          noc_pkg::src_addr1:  state <= noc_pkg::lamport;
          noc_pkg::lamport:    state <= noc_pkg::data0;
          noc_pkg::data0:      state <= noc_pkg::data1;
          noc_pkg::data1: begin
            state               <= noc_pkg::data2;
            receive_nearly_done <= 1'b1;
          end
          noc_pkg::data2: begin
            state        <= noc_pkg::dest_addr0;
            packet_data  <= assembled;
            packet_valid <= 1'b1;
            receive_done <= 1'b1;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beat_taken) begin
      case (state)
        noc_pkg::dest_addr0: temp_packet.dest_addr.hw_addr <= word;
        noc_pkg::dest_addr1: begin
          {temp_packet.dest_addr.sw_addr, temp_packet.dest_addr.port,
           temp_packet.dest_addr.flag} <= word[31:8];  // low byte is padding
        end
        noc_pkg::src_addr0:  temp_packet.src_addr.hw_addr <= word;
        noc_pkg::src_addr1: begin
          {temp_packet.src_addr.sw_addr, temp_packet.src_addr.port,
           temp_packet.src_addr.flag} <= word[31:8];
        end
        noc_pkg::lamport:    temp_packet.lamport <= word;
        noc_pkg::data0:      temp_packet.data[31:0] <= word;
        noc_pkg::data1:      temp_packet.data[63:32] <= word;
        noc_pkg::data2:      temp_packet.data[95:64] <= word;
      endcase
    end
  end

  // framing must match the sender's beat order
  a_sop_on_first: assert property (@(posedge clk) disable iff (!reset_n)
    beat_taken && state == noc_pkg::dest_addr0
      |-> rx_beat.startofpacket && !rx_beat.endofpacket)
    else $error("%0t:%m - first beat without startofpacket", $time);

  a_eop_on_last: assert property (@(posedge clk) disable iff (!reset_n)
    beat_taken && state == noc_pkg::data2
      |-> rx_beat.endofpacket && !rx_beat.startofpacket)
    else $error("%0t:%m - last beat without endofpacket", $time);

  a_no_marker_mid: assert property (@(posedge clk) disable iff (!reset_n)
    beat_taken && !(state inside {noc_pkg::dest_addr0, noc_pkg::data2})
      |-> !rx_beat.startofpacket && !rx_beat.endofpacket)
    else $error("%0t:%m - packet marker on a middle beat", $time);

endmodule : packet_receiver

`default_nettype wire

/* src/packet_link_top.sv */
`timescale 1ns/100ps
`default_nettype none

module packet_link_top #(
  parameter int FIFO_DEPTH = 8  // power of two, 2 to 64
) (
  input  logic             clk,
  input  logic             reset_n,
  input  noc_pkg::packet_t send_packet,
  input  logic             send_valid,
  output logic             send_ready,
  input  logic             booting,
  output logic             packet_valid,
  output noc_pkg::packet_t packet_data,
  output logic             receive_done,
  output logic             receive_nearly_done
);

  noc_pkg::stream_beat_t tx_beat;  // sender to FIFO
  logic                  tx_valid;
  logic                  tx_ready;
  noc_pkg::stream_beat_t rx_beat;  // FIFO to receiver
  logic                  rx_valid;
  logic                  rx_ready;

  packet_sender packet_sender_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .send_packet (send_packet),
    .send_valid  (send_valid),
    .send_ready  (send_ready),
    .tx_beat     (tx_beat),
    .tx_valid    (tx_valid),
    .tx_ready    (tx_ready)
  );

  stream_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) stream_fifo_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .in_beat   (tx_beat),
    .in_valid  (tx_valid),
    .in_ready  (tx_ready),
    .out_beat  (rx_beat),
    .out_valid (rx_valid),
    .out_ready (rx_ready)
  );

  packet_receiver packet_receiver_i (
    .clk                 (clk),
    .reset_n             (reset_n),
    .rx_beat             (rx_beat),
    .rx_valid            (rx_valid),
    .rx_ready            (rx_ready),
    .booting             (booting),
    .packet_valid        (packet_valid),
    .packet_data         (packet_data),
    .receive_done        (receive_done),
    .receive_nearly_done (receive_nearly_done)
  );

endmodule : packet_link_top

`default_nettype wire

/* dv/packet_link_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module packet_link_tb;

  localparam int FIFO_DEPTH  = 8;
  localparam int NUM_ENTRIES = 12;
  localparam int BOOT_ENTRY  = 6;   // packets after this one queue up behind boot
  localparam int MAX_BOOT    = 30;
  localparam int TIMEOUT_NS  = NUM_ENTRIES *
    (noc_pkg::BEATS_PER_PACKET + 2 + MAX_BOOT + FIFO_DEPTH) * 8 * 2;

  typedef struct packed {
    noc_pkg::packet_t pkt;
    int               boot_cycles;  // booting raised before this send
  } stim_t;

  logic             clk;
  logic             reset_n;
  noc_pkg::packet_t send_packet;
  logic             send_valid;
  logic             send_ready;
  logic             booting;
  logic             packet_valid;
  noc_pkg::packet_t packet_data;
  logic             receive_done;
  logic             receive_nearly_done;

  stim_t            stim_table [NUM_ENTRIES];
  noc_pkg::packet_t exp_q [$];
  int               seed         = 99;
  int               boot_left    = 0;
  int               nearly_count = 0;  // nearly-done pulses since last done
  int               sent         = 0;
  int               received     = 0;
  int               errors       = 0;

  packet_link_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) packet_link_top_i (
    .clk                 (clk),
    .reset_n             (reset_n),
    .send_packet         (send_packet),
    .send_valid          (send_valid),
    .send_ready          (send_ready),
    .booting             (booting),
    .packet_valid        (packet_valid),
    .packet_data         (packet_data),
    .receive_done        (receive_done),
    .receive_nearly_done (receive_nearly_done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic fill_table();
    logic [8*32-1:0] raw;  // a few more random bits than one packet holds
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      for (int w = 0; w < 8; w++) begin
        raw[w*32 +: 32] = $random(seed);
      end
      stim_table[i].pkt         = raw[$bits(noc_pkg::packet_t)-1:0];
      stim_table[i].boot_cycles = 0;
    end
    stim_table[0].pkt                    = '1;
    stim_table[1].pkt                    = '0;
    stim_table[2].pkt.dest_addr.flag     = 1'b1;
    stim_table[2].pkt.src_addr.flag      = 1'b1;
    stim_table[BOOT_ENTRY].boot_cycles   = MAX_BOOT;
  endtask

  task automatic check_reset_values();
    assert (!packet_valid && !receive_done && !receive_nearly_done) else begin
      errors++;
      $display("Error at %0d ns: receiver strobe high after reset", $time);
    end
    assert (packet_data == '0) else begin
      errors++;
      $display("Error at %0d ns: packet_data %h not zero after reset", $time, packet_data);
    end
    assert (send_ready) else begin
      errors++;
      $display("Error at %0d ns: send_ready low after reset", $time);
    end
  endtask

  // called at posedge+1, returns at posedge+1 after the accepting edge
  task automatic send_one(input noc_pkg::packet_t p);
    logic taken;
    taken       = 1'b0;
    send_packet = p;
    send_valid  = 1'b1;
    while (!taken) begin
      taken = send_ready;  // holds until the next edge
      @(posedge clk);
      #1;
    end
    send_valid = 1'b0;
    exp_q.push_back(p);
    sent++;
  endtask

  // booting driver, one step later than the send path
  initial begin
    booting = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      if (boot_left > 0) begin
        booting = 1'b1;
        boot_left--;
        if (boot_left == 0) begin
          assert (!send_ready) else begin
            errors++;
            $display("Error at %0d ns: send_ready still high at end of boot", $time);
          end
        end
      end else begin
        booting = 1'b0;
      end
    end
  end

  always @(negedge clk) begin : monitor
    noc_pkg::packet_t exp_pkt;
    if (reset_n) begin
      assert (receive_done == packet_valid) else begin
        errors++;
        $display("Error at %0d ns: receive_done %b, packet_valid %b", $time,
                 receive_done, packet_valid);
      end
      assert (!(packet_valid && booting)) else begin
        errors++;
        $display("Error at %0d ns: packet_valid while booting", $time);
      end
      if (packet_valid) begin
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("Error at %0d ns: packet_valid with nothing outstanding", $time);
        end
        if (exp_q.size() != 0) begin
          exp_pkt = exp_q.pop_front();
          received++;
          assert (packet_data == exp_pkt) else begin
            errors++;
            $display("Error at %0d ns: packet %0d got %h, expected %h", $time,
                     received - 1, packet_data, exp_pkt);
          end
        end
        assert (nearly_count == 1) else begin
          errors++;
          $display("Error at %0d ns: %0d nearly-done pulses before done", $time,
                   nearly_count);
        end
        nearly_count = 0;
      end
      if (receive_nearly_done) begin
        nearly_count++;
      end
    end
  end

  initial begin
    reset_n     = 1'b0;
    send_packet = '0;
    send_valid  = 1'b0;
    fill_table();
    repeat (3) @(posedge clk);
    #1;
    reset_n = 1'b1;
    @(negedge clk);
    check_reset_values();
    @(posedge clk);
    #1;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (stim_table[i].boot_cycles != 0) begin
        while (exp_q.size() != 0) begin  // let the link drain first
          @(posedge clk);
          #1;
        end
        boot_left = stim_table[i].boot_cycles;
      end
      send_one(stim_table[i].pkt);
    end
    while (received < NUM_ENTRIES) @(negedge clk);
    repeat (4) @(negedge clk);
    assert (exp_q.size() == 0 && nearly_count == 0) else begin
      errors++;
      $display("Error at %0d ns: %0d packets left, %0d stray nearly-done pulses",
               $time, exp_q.size(), nearly_count);
    end
    $display("packets sent %0d, received %0d, errors %0d", sent, received, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: only %0d of %0d packets came back within %0d ns", received,
             NUM_ENTRIES, TIMEOUT_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule : packet_link_tb

`default_nettype wire

/* filelist.f */
src/noc_pkg.sv
src/packet_sender.sv
src/stream_fifo.sv
src/packet_receiver.sv
src/packet_link_top.sv
dv/packet_link_tb.sv

/* run.sh */
#!/bin/sh
# compile with Verilator, run, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module packet_link_tb -f filelist.f -o packet_link_sim \
  && ./obj_dir/packet_link_sim | tee /dev/stderr \
     | grep -F "Simulation finished: PASS" > /dev/null \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }
